// ==== compile.f ====
+incdir+verif
logic/busMapPkg.sv
logic/samplePkg.sv
logic/wbRegFile.sv
logic/adcReclock.sv
logic/dacSourceSelect.sv
logic/dacFormat.sv
logic/dacMonitorTop.sv
verif/dacMonitorTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = dacMonitorTb
FILELIST = compile.f
BUILD    = obj_dir

BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)

// ==== verif/tbSupport.svh ====
`ifndef tbSupportSvh
`define tbSupportSvh

// ******************************
// Random source
function automatic logic [31:0] lfsrNext(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};   // x^32+x^22+x^2+x+1
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] randomBits(int width);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < width; i++) begin
        lfsrState = lfsrNext(lfsrState);
        bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
endfunction

// Expected DAC code of one channel
function automatic dacCode_t refCode(adcWord_t word, sample_t level, dacSrc_t src, logic inv);
    int value;
    if (src == srcTest) begin
        value = int'(level);
    end else begin
        value = (int'(word) - (1 << (adcWidth - 1))) * (1 << (sampleWidth - adcWidth));
    end
    if (inv) begin
        value = -value;
    end
    if (value > (1 << (sampleWidth - 1)) - 1) begin
        value = (1 << (sampleWidth - 1)) - 1;    // Full scale clip
    end
    return dacCode_t'((value >>> (sampleWidth - dacWidth)) + (1 << (dacWidth - 1)));
endfunction

// ******************************
// Wishbone master
task automatic busAccess(input logic we, input wbAddr_t addr, input wbData_t data,
                         input wbSel_t sel, output wbData_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= we;
    wbAdr  <= addr;
    wbSel  <= sel;
    wbDatW <= data;
    do begin
        @(negedge clk);
        waited++;
    end while (!wbAck && waited < ackLimit);
    rdata = wbDatR;
    if (!wbAck) begin
        $display("No acknowledge from the register file for address %0d", addr);
        failCount++;
    end else if (waited != 2) begin
        $display("Error at %0t ns: ack came %0d cycles after the strobe", $time, waited - 1);
        failCount++;
    end else begin
        passCount++;
    end
    @(posedge clk);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
    @(negedge clk);
    if (wbAck) begin
        $display("Error at %0t ns: ack still high after the strobe was removed", $time);
        failCount++;
    end else begin
        passCount++;
    end
endtask

task automatic busWrite(wbAddr_t addr, wbData_t data, wbSel_t sel);
    wbData_t ignored;
    busAccess(1'b1, addr, data, sel, ignored);
endtask

task automatic busRead(input wbAddr_t addr, output wbData_t data);
    busAccess(1'b0, addr, '0, '1, data);
endtask

`endif

// ==== verif/dacMonitorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacMonitorTb
    import busMapPkg::*, samplePkg::*;
();

    localparam int resetCycles  = 16;
    localparam int pipeDepth    = 4;     // adc0 to dacND
    localparam int ackLimit     = 8;
    localparam int numRegTrials = 24;
    localparam int numSamples   = 64;
    localparam int accessCycles = 4;
    localparam int testCycles   = resetCycles + 2 * accessCycles
                                + numRegTrials * 2 * accessCycles + 6 * accessCycles
                                + 3 * (numSamples + pipeDepth + 1) + pipeDepth + 2;
    localparam int cycleLimit   = 2 * testCycles;

    localparam wbData_t ctrlMask  = wbData_t'((1 << ctrlInvertBit)
                                  | (((1 << ctrlSrcWidth) - 1) << ctrlSrcLsb));
    localparam wbData_t levelMask = wbData_t'((1 << sampleWidth) - 1);

    logic     clk = 1'b0;
    logic     rstN;
    logic     wbCyc;
    logic     wbStb;
    logic     wbWe;
    wbAddr_t  wbAdr;
    wbSel_t   wbSel;
    wbData_t  wbDatW;
    wbData_t  wbDatR;
    logic     wbAck;
    adcWord_t adc0;
    dacCode_t dac0D;
    dacCode_t dac1D;
    dacCode_t dac2D;
    dacCode_t dacOut [numDacs];

    logic [31:0] lfsrState = 32'hcaaa56da;
    int          passCount = 0;
    int          failCount = 0;
    int          cycleCount;
    int          testNum = 1;
    int          checkMark = 0;
    int          failMark = 0;
    logic        checkOn = 1'b0;
    int          histCount = 0;
    adcWord_t    adcHist [pipeDepth];
    dacCode_t    expected;
    wbData_t     shadowCtrl [numDacs];    // Model of the register contents
    wbData_t     shadowLevel;

    `include "tbSupport.svh"

    dacMonitorTop dut_i (
        .clk(clk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .adc0(adc0), .dac0D(dac0D), .dac1D(dac1D), .dac2D(dac2D)
    );

    assign dacOut[0] = dac0D;
    assign dacOut[1] = dac1D;
    assign dacOut[2] = dac2D;

    always #10 clk = ~clk;

    function automatic wbData_t laneUpdate(wbData_t oldWord, wbData_t newWord, wbSel_t sel);
        wbData_t word;
        word = oldWord;
        for (int b = 0; b < wbSelWidth; b++) begin
            if (sel[b]) begin
                word[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic dacCode_t channelExpect(int ch, adcWord_t word);
        return refCode(word, sample_t'(shadowLevel[sampleWidth-1:0]),
                       dacSrc_t'(shadowCtrl[ch][ctrlSrcLsb +: ctrlSrcWidth]),
                       shadowCtrl[ch][ctrlInvertBit]);
    endfunction

    task automatic reportTest(string name);
        $display("Test %0d %s: %0d checks, %0d failed", testNum, name,
                 passCount + failCount - checkMark, failCount - failMark);
        testNum++;
        checkMark = passCount + failCount;
        failMark  = failCount;
    endtask

    // Random ADC stream, outputs compared while it runs
    task automatic runSamples(int count, bit withExtremes);
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            checkOn = 1'b1;
            if (withExtremes && k % 8 == 0) begin
                adc0 <= '0;                         // Most negative input
            end else if (withExtremes && k % 8 == 4) begin
                adc0 <= '1;
            end else begin
                adc0 <= adcWord_t'(randomBits(adcWidth));
            end
        end
        repeat (pipeDepth + 1) @(posedge clk);
        checkOn = 1'b0;
    endtask

    task automatic writeCtrl(int ch, wbData_t value);
        busWrite(wbAddr_t'(regDac0Ctrl + ch), value, '1);
        shadowCtrl[ch] = value & ctrlMask;
    endtask

    // ******************************
    // Output comparison
    always @(negedge clk) begin
        if (!checkOn) begin
            histCount = 0;
        end else begin
            if (histCount >= pipeDepth) begin
                for (int ch = 0; ch < numDacs; ch++) begin
                    expected = channelExpect(ch, adcHist[pipeDepth-1]);
                    if (dacOut[ch] != expected) begin
                        $display("Error at %0t ns: dac%0d is %h, expected %h",
                                 $time, ch, dacOut[ch], expected);
                        failCount++;
                    end else begin
                        passCount++;
                    end
                end
            end else begin
                histCount++;
            end
            for (int i = pipeDepth - 1; i > 0; i--) begin
                adcHist[i] = adcHist[i-1];
            end
            adcHist[0] = adc0;
        end
    end

    // ******************************
    // Stimulus
    initial begin
        wbData_t rdata;
        wbData_t data;
        wbAddr_t addr;
        wbSel_t  sel;
        int      idx;
        rstN   <= 1'b0;
        wbCyc  <= 1'b0;
        wbStb  <= 1'b0;
        wbWe   <= 1'b0;
        wbAdr  <= '0;
        wbSel  <= '0;
        wbDatW <= '0;
        adc0   <= '0;
        shadowLevel = '0;
        for (int ch = 0; ch < numDacs; ch++) begin
            shadowCtrl[ch] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        busRead(regVersion, rdata);
        if (rdata != wbData_t'(versionNumber)) begin
            $display("Error at %0t ns: version reads %0d, expected %0d",
                     $time, rdata, versionNumber);
            failCount++;
        end else begin
            passCount++;
        end
        busRead(wbAddr_t'(9), rdata);      // Unmapped word
        if (rdata != '0) begin
            $display("Error at %0t ns: unmapped word reads %h", $time, rdata);
            failCount++;
        end else begin
            passCount++;
        end
        reportTest("version and unmapped read");

        for (int n = 0; n < numRegTrials; n++) begin
            addr = wbAddr_t'(regDac0Ctrl + randomBits(2));   // Words 1 to 4
            data = randomBits(32);
            sel  = wbSel_t'(randomBits(wbSelWidth));
            busWrite(addr, data, sel);
            if (addr == regTestLevel) begin
                shadowLevel = laneUpdate(shadowLevel, data, sel) & levelMask;
                busRead(addr, rdata);
                data = shadowLevel;
            end else begin
                idx = int'(addr) - int'(regDac0Ctrl);
                shadowCtrl[idx] = laneUpdate(shadowCtrl[idx], data, sel) & ctrlMask;
                busRead(addr, rdata);
                data = shadowCtrl[idx];
            end
            if (rdata != data) begin
                $display("Error at %0t ns: word %0d reads %h, expected %h",
                         $time, addr, rdata, data);
                failCount++;
            end else begin
                passCount++;
            end
        end
        reportTest("masked register writes");

        for (int ch = 0; ch < numDacs; ch++) begin
            writeCtrl(ch, '0);
        end
        runSamples(numSamples, 1'b0);
        reportTest("ADC to all DACs");

        writeCtrl(1, wbData_t'(1 << ctrlInvertBit));
        runSamples(numSamples, 1'b1);
        @(posedge clk);
        adc0 <= '0;
        repeat (pipeDepth) @(posedge clk);
        @(negedge clk);
        if (dac1D != 14'h3FFF || dac0D != 14'h0000) begin
            $display("Error at %0t ns: zero input gives %h inverted, %h plain",
                     $time, dac1D, dac0D);
            failCount++;
        end else begin
            passCount++;
        end
        reportTest("saturating inversion");

        writeCtrl(2, wbData_t'(srcTest));
        data = randomBits(32);
        busWrite(regTestLevel, data, '1);
        shadowLevel = data & levelMask;
        runSamples(numSamples, 1'b0);
        reportTest("test level source");

        $display("Checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Run length guard
    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles before the tests finished", cycleLimit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/dacMonitorTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacMonitorTop
    import busMapPkg::*, samplePkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    // Wishbone slave
    input  wire logic     wbCyc,
    input  wire logic     wbStb,
    input  wire logic     wbWe,
    input  wire wbAddr_t  wbAdr,
    input  wire wbSel_t   wbSel,
    input  wire wbData_t  wbDatW,
    output wbData_t       wbDatR,
    output logic          wbAck,
    // Converters
    input  wire adcWord_t adc0,
    output dacCode_t      dac0D,
    output dacCode_t      dac1D,
    output dacCode_t      dac2D
);

    dacSrc_t             dacSrc [numDacs];
    logic [numDacs-1:0]  dacInvert;
    sample_t             testLevel;
    sample_t             sample;     // ADC sample, two cycles after the pins
    sample_t             selected [numDacs];

    // ******************************
    // Register space
    wbRegFile regFile (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbSel     (wbSel),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .dacSrc    (dacSrc),
        .dacInvert (dacInvert),
        .testLevel (testLevel)
    );

    // ******************************
    // Sample path
    adcReclock reclock (
        .clk    (clk),
        .rstN   (rstN),
        .adc0   (adc0),
        .sample (sample)
    );

    dacSourceSelect sourceSelect (
        .clk       (clk),
        .rstN      (rstN),
        .sample    (sample),
        .testLevel (testLevel),
        .dacSrc    (dacSrc),
        .selected  (selected)
    );

    // One formatter per monitor DAC
    dacFormat format0 (
        .clk      (clk),
        .rstN     (rstN),
        .selected (selected[0]),
        .invert   (dacInvert[0]),
        .dacCode  (dac0D)
    );

    dacFormat format1 (
        .clk      (clk),
        .rstN     (rstN),
        .selected (selected[1]),
        .invert   (dacInvert[1]),
        .dacCode  (dac1D)
    );

    dacFormat format2 (
        .clk      (clk),
        .rstN     (rstN),
        .selected (selected[2]),
        .invert   (dacInvert[2]),
        .dacCode  (dac2D)
    );

endmodule

`default_nettype wire

// ==== logic/dacFormat.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacFormat
    import samplePkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire sample_t selected,
    input  wire logic    invert,
    output dacCode_t     dacCode
);

    logic    isMostNeg;
    sample_t shaped;

    assign isMostNeg = selected[sampleWidth-1] && !(|selected[sampleWidth-2:0]);

    // Negation would wrap on the most negative value
    always_comb begin
        if (!invert) begin
            shaped = selected;
        end else if (isMostNeg) begin
            shaped = {1'b0, {(sampleWidth-1){1'b1}}};   // Clip to full scale
        end else begin
            shaped = -selected;
        end
    end

    // Keep the top bits, flip the sign back to offset binary
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacCode <= '0;
        end else begin
            dacCode <= {~shaped[sampleWidth-1], shaped[sampleWidth-2 -: dacWidth-1]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/dacSourceSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacSourceSelect
    import samplePkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire sample_t sample,
    input  wire sample_t testLevel,
    input  wire dacSrc_t dacSrc [numDacs],
    output sample_t      selected [numDacs]
);

    // ******************************
    // Per channel source mux
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numDacs; i++) begin
                selected[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numDacs; i++) begin
                case (dacSrc[i])
                    srcTest: selected[i] <= testLevel;
                    default: selected[i] <= sample;    // Reserved codes follow the ADC
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/adcReclock.sv ====
`timescale 1ns/1ps
`default_nettype none

module adcReclock
    import samplePkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire adcWord_t adc0,
    output sample_t       sample
);

    adcWord_t adcReg;    // Pin register

    // Offset binary to two's complement, then left justify into the sample width
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            adcReg <= '0;
            sample <= '0;
        end else begin
            adcReg <= adc0;
            sample <= sample_t'({
                ~adcReg[adcWidth-1],
                adcReg[adcWidth-2:0],
                {(sampleWidth-adcWidth){1'b0}}
            });
        end
    end

endmodule

`default_nettype wire

// ==== logic/wbRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbRegFile
    import busMapPkg::*, samplePkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     wbCyc,
    input  wire logic     wbStb,
    input  wire logic     wbWe,
    input  wire wbAddr_t  wbAdr,
    input  wire wbSel_t   wbSel,
    input  wire wbData_t  wbDatW,
    output wbData_t       wbDatR,
    output logic          wbAck,
    output dacSrc_t       dacSrc [numDacs],
    output logic [numDacs-1:0] dacInvert,
    output sample_t       testLevel
);

    logic    accessStart;
    wbData_t readWord;
    wbData_t ctrlMerged [numDacs];
    wbData_t levelMerged;

    // Replace only the enabled byte lanes
    function automatic wbData_t laneMerge(wbData_t oldWord, wbData_t newWord, wbSel_t sel);
        wbData_t merged;
        merged = oldWord;
        for (int b = 0; b < wbSelWidth; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Unused control bits read back as zero
    function automatic wbData_t ctrlWord(dacSrc_t src, logic inv);
        wbData_t word;
        word = '0;
        word[ctrlSrcLsb +: ctrlSrcWidth] = src;
        word[ctrlInvertBit] = inv;
        return word;
    endfunction

    // ******************************
    // Bus handshake
    assign accessStart = wbCyc && wbStb && !wbAck;   // One ack per strobe

    always_comb begin
        for (int i = 0; i < numDacs; i++) begin
            ctrlMerged[i] = laneMerge(ctrlWord(dacSrc[i], dacInvert[i]), wbDatW, wbSel);
        end
        levelMerged = laneMerge({{(wbDataWidth-sampleWidth){1'b0}}, testLevel}, wbDatW, wbSel);
    end

    // ******************************
    // Writable registers
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck     <= 1'b0;
            dacInvert <= '0;
            testLevel <= '0;
            for (int i = 0; i < numDacs; i++) begin
                dacSrc[i] <= srcAdc;
            end
        end else begin
            wbAck <= accessStart;
            if (accessStart && wbWe) begin
                for (int i = 0; i < numDacs; i++) begin
                    if (wbAdr == wbAddr_t'(regDac0Ctrl + i)) begin
                        dacSrc[i]    <= dacSrc_t'(ctrlMerged[i][ctrlSrcLsb +: ctrlSrcWidth]);
                        dacInvert[i] <= ctrlMerged[i][ctrlInvertBit];
                    end
                end
                if (wbAdr == regTestLevel) begin
                    testLevel <= sample_t'(levelMerged[sampleWidth-1:0]);
                end
            end
        end
    end

    // Read decode
    always_comb begin
        case (wbAdr)
            regVersion:   readWord = wbData_t'(versionNumber);
            regDac0Ctrl:  readWord = ctrlWord(dacSrc[0], dacInvert[0]);
            regDac1Ctrl:  readWord = ctrlWord(dacSrc[1], dacInvert[1]);
            regDac2Ctrl:  readWord = ctrlWord(dacSrc[2], dacInvert[2]);
            regTestLevel: readWord = {{(wbDataWidth-sampleWidth){1'b0}}, testLevel};
            default:      readWord = '0;                 // Unmapped
        endcase
    end

    // Read data is held for the ack cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbDatR <= '0;
        end else if (accessStart) begin
            wbDatR <= readWord;
        end
    end

endmodule

`default_nettype wire

// ==== logic/samplePkg.sv ====
`default_nettype none

package samplePkg;

    localparam int adcWidth    = 14;
    localparam int sampleWidth = 18;
    localparam int dacWidth    = 14;
    localparam int numDacs     = 3;

    // Raw converter words are offset binary
    typedef logic [adcWidth-1:0] adcWord_t;
    typedef logic [dacWidth-1:0] dacCode_t;

    // Internal samples are two's complement
    typedef logic signed [sampleWidth-1:0] sample_t;

    // Monitor source per DAC channel
    typedef enum logic [1:0] {
        srcAdc  = 2'd0,    // Reclocked ADC sample
        srcTest = 2'd1     // Programmable test level
    } dacSrc_t;

endpackage

`default_nettype wire

// ==== logic/busMapPkg.sv ====
`default_nettype none

package busMapPkg;

    // ******************************
    // Bus geometry
    localparam int wbAddrWidth = 4;    // Word address
    localparam int wbDataWidth = 32;
    localparam int wbSelWidth  = 4;    // One strobe per byte lane

    typedef logic [wbAddrWidth-1:0] wbAddr_t;
    typedef logic [wbDataWidth-1:0] wbData_t;
    typedef logic [wbSelWidth-1:0]  wbSel_t;

    localparam int versionNumber = 613;

    // ******************************
    // Register word addresses
    localparam wbAddr_t regVersion   = 4'd0;   // Read only
    localparam wbAddr_t regDac0Ctrl  = 4'd1;
    localparam wbAddr_t regDac1Ctrl  = 4'd2;
    localparam wbAddr_t regDac2Ctrl  = 4'd3;
    localparam wbAddr_t regTestLevel = 4'd4;

    // Control word fields
    localparam int ctrlSrcLsb    = 0;
    localparam int ctrlSrcWidth  = 2;
    localparam int ctrlInvertBit = 4;

endpackage

`default_nettype wire
